/* rtl/texture_pkg.sv */
`default_nettype none

package texture_pkg;

  // ======================================================================
  // image geometry
  // ======================================================================
  localparam int IMG_W = 16;
  localparam int IMG_H = 12;
  localparam int PIX_W = 8;
  localparam int PIX_PER_FRAME = (IMG_W - 2) * (IMG_H - 2);

  typedef logic [PIX_W-1:0] pix_t;
  typedef pix_t [8:0] win_t;      // [0] top-left, [4] centre, row-major

  localparam int MED_LAT = 3;     // median pipeline depth

  // ======================================================================
  // joint histogram
  // ======================================================================
  localparam int NI_LEVELS = 9;
  localparam int NUM_BINS = 2 * NI_LEVELS * NI_LEVELS;
  localparam int CNT_W = 16;

  typedef logic [7:0] bin_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [3:0] lvl_t;      // ni or rd, 0..8

  function automatic bin_t make_bin(input logic ci, input lvl_t ni, input lvl_t rd);
    int idx;
    idx = int'(ci) * NI_LEVELS * NI_LEVELS + int'(ni) * NI_LEVELS + int'(rd);
    return bin_t'(idx);
  endfunction

endpackage

`default_nettype wire

/* rtl/delay_line.sv */
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire payload_t data_i,
  input  wire           valid_i,
  output payload_t      data_o,
  output logic          valid_o
);

  payload_t         data_q [DEPTH];
  logic [DEPTH-1:0] valid_q;

  always_ff @(posedge clk) begin
    data_q[0] <= data_i;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign data_o  = data_q[DEPTH-1];
  assign valid_o = valid_q[DEPTH-1];

endmodule

`default_nettype wire

/* rtl/window_3x3.sv */
`timescale 1ns/10ps
`default_nettype none

module window_3x3 import texture_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire pix_t  pix_i,
  input  wire        pix_valid_i,
  output win_t       win_o,
  output logic       win_valid_o,
  output logic       win_last_o
);

  logic [$clog2(IMG_W)-1:0] col_q;
  logic [$clog2(IMG_H)-1:0] row_q;

  pix_t line0_q [IMG_W];    // previous row
  pix_t line1_q [IMG_W];    // two rows back
  pix_t win_q [3][3];       // [row][col], row 0 oldest

  // ======================================================================
  // position tracking
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_o <= 1'b0;
      win_last_o  <= 1'b0;
    end else begin
      win_valid_o <= pix_valid_i && (row_q >= 2) && (col_q >= 2);
      win_last_o  <= pix_valid_i && (row_q == IMG_H - 1) && (col_q == IMG_W - 1);
      if (pix_valid_i) begin
        if (col_q == IMG_W - 1) begin
          col_q <= '0;
          if (row_q == IMG_H - 1) begin
            row_q <= '0;        // next frame
          end else begin
            row_q <= row_q + 1'b1;
          end
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  // ======================================================================
  // line buffers and column shift
  // ======================================================================
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      line1_q[col_q] <= line0_q[col_q];
      line0_q[col_q] <= pix_i;
      for (int r = 0; r < 3; r++) begin
        win_q[r][0] <= win_q[r][1];
        win_q[r][1] <= win_q[r][2];
      end
      win_q[0][2] <= line1_q[col_q];
      win_q[1][2] <= line0_q[col_q];
      win_q[2][2] <= pix_i;     // newest column on the right
    end
  end

  always_comb begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        win_o[r*3+c] = win_q[r][c];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/median_3x3.sv */
`timescale 1ns/10ps
`default_nettype none

module median_3x3 import texture_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire win_t  win_i,
  input  wire        valid_i,
  output pix_t       med_o,
  output logic       valid_o
);

  pix_t lo_q [3];
  pix_t mid_q [3];
  pix_t hi_q [3];
  pix_t a_q;
  pix_t b_q;
  pix_t c_q;
  logic [MED_LAT-1:0] vld_q;

  function automatic pix_t max2(input pix_t a, input pix_t b);
    return (a > b) ? a : b;
  endfunction

  function automatic pix_t min2(input pix_t a, input pix_t b);
    return (a < b) ? a : b;
  endfunction

  function automatic pix_t med3(input pix_t a, input pix_t b, input pix_t c);
    return max2(min2(a, b), min2(max2(a, b), c));
  endfunction

  // ======================================================================
  // stage 1 sorts each row, stage 2 reduces columns, stage 3 picks median
  // ======================================================================
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      lo_q[r]  <= min2(min2(win_i[3*r], win_i[3*r+1]), win_i[3*r+2]);
      mid_q[r] <= med3(win_i[3*r], win_i[3*r+1], win_i[3*r+2]);
      hi_q[r]  <= max2(max2(win_i[3*r], win_i[3*r+1]), win_i[3*r+2]);
    end
    a_q   <= max2(max2(lo_q[0], lo_q[1]), lo_q[2]);     // largest low
    b_q   <= med3(mid_q[0], mid_q[1], mid_q[2]);
    c_q   <= min2(min2(hi_q[0], hi_q[1]), hi_q[2]);     // smallest high
    med_o <= med3(a_q, b_q, c_q);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[MED_LAT-2:0], valid_i};
    end
  end

  assign valid_o = vld_q[MED_LAT-1];

endmodule

`default_nettype wire

/* rtl/texture_code.sv */
`timescale 1ns/10ps
`default_nettype none

module texture_code import texture_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire win_t  win_i,
  input  wire pix_t  med_i,
  input  wire        valid_i,
  input  wire        last_i,
  output bin_t       bin_o,
  output logic       bin_valid_o,
  output logic       bin_last_o
);

  lvl_t ni_c;
  lvl_t rd_c;
  logic ci_c;

  always_comb begin
    ni_c = '0;
    rd_c = '0;
    for (int i = 0; i < 9; i++) begin
      if (i != 4) begin                     // neighbours only
        if (win_i[i] >= med_i) begin
          ni_c = ni_c + 1'b1;
        end
        if (win_i[i] >= win_i[4]) begin
          rd_c = rd_c + 1'b1;
        end
      end
    end
    ci_c = (win_i[4] >= med_i);
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      bin_o <= make_bin(ci_c, ni_c, rd_c);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bin_valid_o <= 1'b0;
      bin_last_o  <= 1'b0;
    end else begin
      bin_valid_o <= valid_i;
      bin_last_o  <= valid_i && last_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/joint_histogram.sv */
`timescale 1ns/10ps
`default_nettype none

module joint_histogram import texture_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire bin_t  bin_i,
  input  wire        bin_valid_i,
  input  wire        bin_last_i,
  input  wire        read_en_i,
  output cnt_t       hist_o,
  output logic       hist_valid_o,
  output logic       read_done_o,
  output logic       frame_done_o
);

  cnt_t                mem_q [NUM_BINS];
  logic [NUM_BINS-1:0] used_q;      // bin holds a count this frame

  bin_t s1_bin_q;
  cnt_t s1_cnt_q;
  logic s1_vld_q;
  logic s1_last_q;

  bin_t s2_bin_q;
  cnt_t s2_cnt_q;
  logic s2_vld_q;
  logic s2_last_q;

  cnt_t base_c;
  bin_t rd_ptr_q;
  logic fin_pend_q;                 // bin 161 just read
  logic rd_acc_c;

  assign rd_acc_c = read_en_i && frame_done_o && !fin_pend_q;

  // ======================================================================
  // update pipeline: read, increment, write
  // ======================================================================
  always_ff @(posedge clk) begin
    s1_bin_q <= bin_i;
    if (s2_vld_q && (s2_bin_q == bin_i)) begin
      s1_cnt_q <= s2_cnt_q;         // write lands on this same edge
    end else if (used_q[bin_i]) begin
      s1_cnt_q <= mem_q[bin_i];
    end else begin
      s1_cnt_q <= '0;
    end
  end

  // back-to-back hit on the same bin
  assign base_c = (s2_vld_q && (s2_bin_q == s1_bin_q)) ? s2_cnt_q : s1_cnt_q;

  always_ff @(posedge clk) begin
    s2_bin_q <= s1_bin_q;
    s2_cnt_q <= base_c + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (s2_vld_q) begin
      mem_q[s2_bin_q] <= s2_cnt_q;
    end
    if (rd_acc_c) begin
      hist_o <= used_q[rd_ptr_q] ? mem_q[rd_ptr_q] : '0;
    end
  end

  // ======================================================================
  // control, frame done and readout
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld_q     <= 1'b0;
      s1_last_q    <= 1'b0;
      s2_vld_q     <= 1'b0;
      s2_last_q    <= 1'b0;
      used_q       <= '0;
      rd_ptr_q     <= '0;
      fin_pend_q   <= 1'b0;
      hist_valid_o <= 1'b0;
      read_done_o  <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      s1_vld_q     <= bin_valid_i;
      s1_last_q    <= bin_valid_i && bin_last_i;
      s2_vld_q     <= s1_vld_q;
      s2_last_q    <= s1_last_q;
      hist_valid_o <= rd_acc_c;
      read_done_o  <= fin_pend_q;
      fin_pend_q   <= 1'b0;
      if (s2_vld_q) begin
        used_q[s2_bin_q] <= 1'b1;
      end
      if (s2_vld_q && s2_last_q) begin
        frame_done_o <= 1'b1;       // last count written
      end
      if (rd_acc_c) begin
        used_q[rd_ptr_q] <= 1'b0;   // clear on read
        if (rd_ptr_q == NUM_BINS - 1) begin
          rd_ptr_q   <= '0;
          fin_pend_q <= 1'b1;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      if (fin_pend_q) begin
        frame_done_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/texture_top.sv */
`timescale 1ns/10ps
`default_nettype none

module texture_top import texture_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire pix_t  pix_i,
  input  wire        pix_valid_i,
  input  wire        read_en_i,
  output cnt_t       hist_o,
  output logic       hist_valid_o,
  output logic       read_done_o,
  output logic       frame_done_o
);

  win_t win;
  logic win_valid;
  logic win_last;
  pix_t med;
  logic med_valid;
  win_t win_d;                      // aligned with med
  logic win_last_d;
  bin_t bin;
  logic bin_valid;
  logic bin_last;

  // ======================================================================
  // window and median
  // ======================================================================
  window_3x3 u_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .win_o       (win),
    .win_valid_o (win_valid),
    .win_last_o  (win_last)
  );

  median_3x3 u_median (
    .clk     (clk),
    .rst_n   (rst_n),
    .win_i   (win),
    .valid_i (win_valid),
    .med_o   (med),
    .valid_o (med_valid)
  );

  delay_line #(.payload_t(win_t), .DEPTH(MED_LAT)) dly_win (
    .clk     (clk),
    .rst_n   (rst_n),
    .data_i  (win),
    .valid_i (win_valid),
    .data_o  (win_d),
    .valid_o ()
  );

  delay_line #(.payload_t(logic), .DEPTH(MED_LAT)) dly_last (
    .clk     (clk),
    .rst_n   (rst_n),
    .data_i  (win_last),
    .valid_i (win_valid),
    .data_o  (win_last_d),
    .valid_o ()
  );

  // ======================================================================
  // codes and histogram
  // ======================================================================
  texture_code u_code (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_i       (win_d),
    .med_i       (med),
    .valid_i     (med_valid),
    .last_i      (win_last_d),
    .bin_o       (bin),
    .bin_valid_o (bin_valid),
    .bin_last_o  (bin_last)
  );

  joint_histogram u_hist (
    .clk          (clk),
    .rst_n        (rst_n),
    .bin_i        (bin),
    .bin_valid_i  (bin_valid),
    .bin_last_i   (bin_last),
    .read_en_i    (read_en_i),
    .hist_o       (hist_o),
    .hist_valid_o (hist_valid_o),
    .read_done_o  (read_done_o),
    .frame_done_o (frame_done_o)
  );

endmodule

`default_nettype wire

/* verif/texture_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module texture_chk (
  input  wire clk,
  input  wire rst_n,
  input  wire read_en_i,
  input  wire hist_valid_i,
  input  wire read_done_i,
  input  wire frame_done_i
);

  // ======================================================================
  // readout protocol
  // ======================================================================
  a_valid_in_window: assert property (@(posedge clk) disable iff (!rst_n)
    hist_valid_i |-> (frame_done_i || read_done_i))
    else $error("hist_valid_o seen outside the readout window");

  a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_done_i |=> !read_done_i)
    else $error("read_done_o held for more than one cycle");

  a_valid_after_en: assert property (@(posedge clk) disable iff (!rst_n)
    hist_valid_i |-> $past(read_en_i))    // registered read path
    else $error("hist_valid_o without read_en_i one cycle before");

endmodule

`default_nettype wire

/* verif/tb_texture.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_texture
  import texture_pkg::*;
();

  localparam int SEED        = 60821;
  localparam int NUM_FRAMES  = 5;
  localparam int MARGIN      = 300;
  localparam int CYCLE_LIMIT = NUM_FRAMES * (IMG_W * IMG_H + 2 * NUM_BINS + MARGIN) + 40;
  localparam bin_t FLAT_BIN  = bin_t'(1 * 81 + 8 * 9 + 8);   // ci 1, ni 8, rd 8

  logic clk;
  logic rst_n;
  pix_t pix_i;
  logic pix_valid_i;
  logic read_en_i;
  cnt_t hist_o;
  logic hist_valid_o;
  logic read_done_o;
  logic frame_done_o;

  logic [31:0] rand_state;
  pix_t        frame_q [IMG_W*IMG_H];   // raster order
  int          exp_hist [NUM_BINS];
  cnt_t        got_hist [NUM_BINS];
  int          cycles = 0;
  int          done_cnt = 0;

  texture_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_i        (pix_i),
    .pix_valid_i  (pix_valid_i),
    .read_en_i    (read_en_i),
    .hist_o       (hist_o),
    .hist_valid_o (hist_valid_o),
    .read_done_o  (read_done_o),
    .frame_done_o (frame_done_o)
  );

  bind texture_top texture_chk chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .read_en_i    (read_en_i),
    .hist_valid_i (hist_valid_o),
    .read_done_i  (read_done_o),
    .frame_done_i (frame_done_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: readout did not complete within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "run stopped on timeout");
    end
  end

  always @(negedge clk) begin
    if (rst_n && read_done_o) begin
      done_cnt = done_cnt + 1;
    end
  end

  function automatic logic [15:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state[31:16];
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  // ======================================================================
  // stimulus and reference model
  // ======================================================================
  task automatic make_frame(input int mode);
    pix_t base;
    base = pix_t'(next_rand());
    for (int i = 0; i < IMG_W * IMG_H; i++) begin
      case (mode)
        0:       frame_q[i] = pix_t'(next_rand());
        1:       frame_q[i] = base + pix_t'(next_rand() % 4);  // many ties
        default: frame_q[i] = base;
      endcase
    end
  endtask

  task automatic compute_expected();
    pix_t nb [9];
    pix_t srt [9];
    pix_t tmp;
    pix_t med;
    int   ci;
    int   ni;
    int   rd;
    for (int b = 0; b < NUM_BINS; b++) begin
      exp_hist[b] = 0;
    end
    for (int y = 1; y < IMG_H - 1; y++) begin
      for (int x = 1; x < IMG_W - 1; x++) begin
        for (int k = 0; k < 9; k++) begin
          nb[k]  = frame_q[(y + k / 3 - 1) * IMG_W + x + k % 3 - 1];
          srt[k] = nb[k];
        end
        for (int i = 0; i < 8; i++) begin
          for (int j = 0; j < 8 - i; j++) begin
            if (srt[j] > srt[j+1]) begin
              tmp      = srt[j];
              srt[j]   = srt[j+1];
              srt[j+1] = tmp;
            end
          end
        end
        med = srt[4];
        ci  = (nb[4] >= med) ? 1 : 0;
        ni  = 0;
        rd  = 0;
        for (int k = 0; k < 9; k++) begin
          if (k != 4 && nb[k] >= med) ni++;
          if (k != 4 && nb[k] >= nb[4]) rd++;
        end
        exp_hist[ci * 81 + ni * 9 + rd]++;
      end
    end
  endtask

  task automatic send_frame(input bit gaps);
    for (int i = 0; i < IMG_W * IMG_H; i++) begin
      while (gaps && (next_rand() % 4 == 0)) begin
        @(posedge clk);
        pix_valid_i <= 1'b0;
      end
      @(posedge clk);
      pix_valid_i <= 1'b1;
      pix_i       <= frame_q[i];
    end
    @(posedge clk);
    pix_valid_i <= 1'b0;
  endtask

  // ======================================================================
  // readout and checks
  // ======================================================================
  task automatic check_idle();
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      read_en_i <= 1'b1;
      @(negedge clk);
      assert (!frame_done_o && !hist_valid_o && !read_done_o)
        else report_error("readout activity before any frame");
    end
    @(posedge clk);
    read_en_i <= 1'b0;
  endtask

  task automatic read_hist(input bit pauses);
    int n;
    int sum;
    bit done;
    n    = 0;
    sum  = 0;
    done = 1'b0;
    @(negedge clk);
    while (!frame_done_o) @(negedge clk);
    while (!done) begin
      @(posedge clk);
      read_en_i <= pauses ? (next_rand() % 4 != 0) : 1'b1;
      @(negedge clk);
      if (hist_valid_o) begin
        assert (n < NUM_BINS) else report_error("more bins streamed than exist");
        assert (hist_o == cnt_t'(exp_hist[n]))
          else report_error($sformatf("bin %0d got %0d expected %0d", n, hist_o, exp_hist[n]));
        assert (frame_done_o) else report_error("frame_done_o low during readout");
        got_hist[n] = hist_o;
        sum = sum + int'(hist_o);
        n++;
      end
      if (read_done_o) begin
        assert (n == NUM_BINS)
          else report_error($sformatf("read_done_o after %0d bins", n));
        assert (!frame_done_o) else report_error("frame_done_o still high at read_done_o");
        done = 1'b1;
      end
    end
    @(posedge clk);
    read_en_i <= 1'b0;
    assert (sum == PIX_PER_FRAME)
      else report_error($sformatf("counts sum to %0d expected %0d", sum, PIX_PER_FRAME));
  endtask

  initial begin
    int mode;
    bit gaps;
    bit pauses;
    rand_state  = SEED;
    rst_n       = 1'b0;
    pix_i       = '0;
    pix_valid_i = 1'b0;
    read_en_i   = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_idle();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      mode   = (f == 2) ? 2 : ((f == 3) ? 1 : 0);  // frame 2 is flat
      gaps   = (f != 2) && (f != 4);
      pauses = (f >= 1) && (f <= 3);
      make_frame(mode);
      compute_expected();
      send_frame(gaps);
      read_hist(pauses);
      if (mode == 2) begin
        assert (got_hist[FLAT_BIN] == cnt_t'(PIX_PER_FRAME))
          else report_error($sformatf("flat frame bin %0d got %0d expected %0d",
                                      FLAT_BIN, got_hist[FLAT_BIN], PIX_PER_FRAME));
      end
    end
    assert (done_cnt == NUM_FRAMES)
      else report_error($sformatf("%0d read_done_o pulses for %0d frames", done_cnt, NUM_FRAMES));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/texture_pkg.sv
rtl/delay_line.sv
rtl/window_3x3.sv
rtl/median_3x3.sv
rtl/texture_code.sv
rtl/joint_histogram.sv
rtl/texture_top.sv
verif/texture_chk.sv
verif/tb_texture.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_texture
FILELIST  := src.f
BUILD     := obj_dir
FLAGS     := --binary --assert -Wno-fatal -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
